/* rtl/mau_defines.svh */
`ifndef MAU_DEFINES_SVH
`define MAU_DEFINES_SVH

// ---------------------------------------------------------
// datapath widths
// ---------------------------------------------------------

// byte address
`define MAU_ADDR_W 32

// register data as seen by the core
`define MAU_DATA_W 32

// one single-beat bus transfer
`define MAU_BUS_W 64

// one strobe bit per bus byte
`define MAU_STRB_W 8

// transaction id from a free-running counter
`define MAU_ID_W 4

`endif

/* rtl/mau_pkg.sv */
`include "mau_defines.svh"

package mau_pkg;

	// loads first, then stores
	typedef enum logic [2:0] {
		OP_LW  = 3'd0,
		OP_LH  = 3'd1,
		OP_LHU = 3'd2,
		OP_LB  = 3'd3,
		OP_LBU = 3'd4,
		OP_SW  = 3'd5,
		OP_SH  = 3'd6,
		OP_SB  = 3'd7
	} mem_op_e;

	typedef struct packed {
		mem_op_e                op;
		logic [`MAU_ADDR_W-1:0] addr;
		logic [`MAU_DATA_W-1:0] data;
	} mem_req_t;

	// how one access maps onto one or two bus beats
	typedef struct packed {
		logic                   split;
		logic [`MAU_ADDR_W-1:0] addr0;
		logic [`MAU_ADDR_W-1:0] addr1;
		logic [`MAU_STRB_W-1:0] strb0;
		logic [`MAU_STRB_W-1:0] strb1;
		logic [2:0]             size;
		logic [`MAU_BUS_W-1:0]  wbeat;
	} lane_plan_t;

	// ---------------------------------------------------------
	// bus channels
	// ---------------------------------------------------------

	typedef struct packed {
		logic [`MAU_ADDR_W-1:0] addr;
		logic [`MAU_ID_W-1:0]   id;
		logic [2:0]             size;
	} axi_ar_t;

	// write address has the read address layout
	typedef axi_ar_t axi_aw_t;

	typedef struct packed {
		logic [`MAU_BUS_W-1:0]  data;
		logic [`MAU_STRB_W-1:0] strb;
		logic                   last;
	} axi_w_t;

	typedef struct packed {
		logic [`MAU_BUS_W-1:0] data;
		logic [`MAU_ID_W-1:0]  id;
		logic [1:0]            resp;
	} axi_r_t;

	typedef struct packed {
		logic [`MAU_ID_W-1:0] id;
		logic [1:0]           resp;
	} axi_b_t;

endpackage

/* rtl/lane_planner.sv */
`timescale 1ns/1ps
`include "mau_defines.svh"

module lane_planner (
	input  mau_pkg::mem_op_e       op,
	input  logic [`MAU_ADDR_W-1:0] addr,
	input  logic [`MAU_DATA_W-1:0] store_data,
	output mau_pkg::lane_plan_t    plan
);
	import mau_pkg::*;

	logic                    is_word;
	logic                    is_half;
	logic                    split;
	logic [3:0]              byte_mask;
	logic [7:0]              spread;
	logic [`MAU_ADDR_W-1:0]  word_addr;
	logic [`MAU_ADDR_W-1:0]  next_addr;
	logic [`MAU_BUS_W-1:0]   wide_data;
	logic [2*`MAU_BUS_W-1:0] doubled;
	logic [5:0]              rot_bits;

	// ---------------------------------------------------------
	// access class
	// ---------------------------------------------------------

	assign is_word = (op == OP_LW) || (op == OP_SW);
	assign is_half = (op == OP_LH) || (op == OP_LHU) || (op == OP_SH);

	// word off its 4-byte boundary, or half on the last byte
	assign split = (is_word && (addr[1:0] != 2'b00)) ||
		(is_half && (addr[1:0] == 2'b11));

	always_comb begin
		if (is_word) begin
			byte_mask = 4'b1111;
		end else if (is_half) begin
			byte_mask = 4'b0011;
		end else begin
			byte_mask = 4'b0001;
		end
	end

	// ---------------------------------------------------------
	// addresses and strobes
	// ---------------------------------------------------------

	// low nibble stays in this word, high nibble spills to the next
	assign spread = {4'b0000, byte_mask} << addr[1:0];

	assign word_addr = {addr[`MAU_ADDR_W-1:2], 2'b00};
	assign next_addr = word_addr + 4;

	assign plan.split = split;
	assign plan.addr0 = addr;
	assign plan.addr1 = next_addr;

	// move the word's nibble to the upper half of the beat when bit 2 is set
	assign plan.strb0 = {4'b0000, spread[3:0]} << {addr[2], 2'b00};
	assign plan.strb1 = split ? ({4'b0000, spread[7:4]} << {next_addr[2], 2'b00}) : '0;

	always_comb begin
		if (is_word) begin
			plan.size = 3'd2;
		end else if (is_half) begin
			plan.size = 3'd1;
		end else begin
			plan.size = 3'd0;
		end
	end

	// ---------------------------------------------------------
	// write beat
	// ---------------------------------------------------------

	// rotate left by whole bytes, the top half of the doubled value wraps around
	assign wide_data  = {{(`MAU_BUS_W-`MAU_DATA_W){1'b0}}, store_data};
	assign rot_bits   = {addr[2:0], 3'b000};
	assign doubled    = {wide_data, wide_data} << rot_bits;
	assign plan.wbeat = doubled[2*`MAU_BUS_W-1:`MAU_BUS_W];

endmodule

/* rtl/axi_read_fsm.sv */
`timescale 1ns/1ps
`include "mau_defines.svh"

module axi_read_fsm (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start,
	input  mau_pkg::lane_plan_t   plan,
	input  logic [`MAU_ID_W-1:0]  txn_id,
	output mau_pkg::axi_ar_t      ar,
	output logic                  arvalid,
	input  logic                  arready,
	input  mau_pkg::axi_r_t       r,
	input  logic                  rvalid,
	output logic                  rready,
	output logic [`MAU_BUS_W-1:0] first_beat,
	output logic [`MAU_BUS_W-1:0] last_beat,
	output logic                  read_done
);

	typedef enum logic [1:0] {
		S_IDLE  = 2'd0,
		S_ADDR  = 2'd1,
		S_DATA  = 2'd2,
		S_ADDR2 = 2'd3
	} state_e;

	state_e state;
	logic   second_q;
	logic   issue;
	logic   resp_ok;

	// new address goes out from idle or from the second-address state
	assign issue   = ((state == S_IDLE) && start) || (state == S_ADDR2);
	// stale ids are consumed but never count
	assign resp_ok = rvalid && rready && (r.id == ar.id);

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= S_IDLE;
			arvalid   <= 1'b0;
			rready    <= 1'b0;
			second_q  <= 1'b0;
			read_done <= 1'b0;
		end else begin
			read_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						arvalid  <= 1'b1;
						second_q <= 1'b0;
						state    <= S_ADDR;
					end
				end
				S_ADDR: begin
					if (arready) begin
						arvalid <= 1'b0;
						rready  <= 1'b1;
						state   <= S_DATA;
					end
				end
				S_DATA: begin
					if (resp_ok) begin
						rready <= 1'b0;
						if (plan.split && !second_q) begin
							state <= S_ADDR2;
						end else begin
							read_done <= 1'b1;
							state     <= S_IDLE;
						end
					end
				end
				S_ADDR2: begin
					arvalid  <= 1'b1;
					second_q <= 1'b1;
					state    <= S_ADDR;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// ---------------------------------------------------------
	// address payload and read beats
	// ---------------------------------------------------------

	always_ff @(posedge clock) begin
		if (issue) begin
			ar.addr <= (state == S_ADDR2) ? plan.addr1 : plan.addr0;
			ar.id   <= txn_id;
			ar.size <= plan.size;
		end
		if (resp_ok) begin
			if (!second_q) begin
				first_beat <= r.data;
			end
			last_beat <= r.data;
		end
	end

	ar_held: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(ar));

endmodule

/* rtl/axi_write_fsm.sv */
`timescale 1ns/1ps
`include "mau_defines.svh"

module axi_write_fsm (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 start,
	input  mau_pkg::lane_plan_t  plan,
	input  logic [`MAU_ID_W-1:0] txn_id,
	output mau_pkg::axi_aw_t     aw,
	output logic                 awvalid,
	input  logic                 awready,
	output mau_pkg::axi_w_t      w,
	output logic                 wvalid,
	input  logic                 wready,
	input  mau_pkg::axi_b_t      b,
	input  logic                 bvalid,
	output logic                 bready,
	output logic                 write_done
);

	typedef enum logic [2:0] {
		S_IDLE = 3'd0,
		S_AW   = 3'd1,
		S_W    = 3'd2,
		S_B    = 3'd3,
		S_AW2  = 3'd4
	} state_e;

	state_e state;
	logic   second_q;
	logic   issue;
	logic   aw_fire;
	logic   resp_ok;

	assign issue   = ((state == S_IDLE) && start) || (state == S_AW2);
	assign aw_fire = awvalid && awready;
	assign resp_ok = bvalid && bready && (b.id == aw.id);

	// ---------------------------------------------------------
	// aw, then w, then b, once or twice
	// ---------------------------------------------------------

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= S_IDLE;
			awvalid    <= 1'b0;
			wvalid     <= 1'b0;
			bready     <= 1'b0;
			second_q   <= 1'b0;
			write_done <= 1'b0;
		end else begin
			write_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						awvalid  <= 1'b1;
						second_q <= 1'b0;
						state    <= S_AW;
					end
				end
				S_AW: begin
					if (awready) begin
						awvalid <= 1'b0;
						wvalid  <= 1'b1;
						state   <= S_W;
					end
				end
				S_W: begin
					if (wready) begin
						wvalid <= 1'b0;
						bready <= 1'b1;
						state  <= S_B;
					end
				end
				S_B: begin
					// mismatched ids are swallowed here
					if (resp_ok) begin
						bready <= 1'b0;
						if (plan.split && !second_q) begin
							state <= S_AW2;
						end else begin
							write_done <= 1'b1;
							state      <= S_IDLE;
						end
					end
				end
				S_AW2: begin
					awvalid  <= 1'b1;
					second_q <= 1'b1;
					state    <= S_AW;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// ---------------------------------------------------------
	// channel payloads
	// ---------------------------------------------------------

	always_ff @(posedge clock) begin
		if (issue) begin
			aw.addr <= (state == S_AW2) ? plan.addr1 : plan.addr0;
			aw.id   <= txn_id;
			aw.size <= plan.size;
		end
		// only the strobes move between the two beats
		if (aw_fire) begin
			w.data <= plan.wbeat;
			w.strb <= second_q ? plan.strb1 : plan.strb0;
			w.last <= 1'b1;
		end
	end

	aw_held: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(aw));

	w_held: assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(w));

endmodule

/* rtl/load_aligner.sv */
`timescale 1ns/1ps
`include "mau_defines.svh"

module load_aligner (
	input  mau_pkg::lane_plan_t    plan,
	input  mau_pkg::mem_op_e       op,
	input  logic [1:0]             addr_low,
	input  logic [`MAU_BUS_W-1:0]  first_beat,
	input  logic [`MAU_BUS_W-1:0]  last_beat,
	output logic [`MAU_DATA_W-1:0] load_data
);
	import mau_pkg::*;

	logic [`MAU_DATA_W-1:0]   group;
	logic [2*`MAU_DATA_W-1:0] shifted;
	logic [`MAU_DATA_W-1:0]   rotated;

	// ---------------------------------------------------------
	// gather strobed bytes into one 4-byte group
	// ---------------------------------------------------------

	// each group lane comes from the low or high half of either beat
	always_comb begin
		group = '0;
		for (int i = 0; i < 4; i++) begin
			group[8*i +: 8] = ({8{plan.strb0[i]}}     & first_beat[8*i +: 8])
				| ({8{plan.strb0[i+4]}} & first_beat[8*(i+4) +: 8])
				| ({8{plan.strb1[i]}}   & last_beat[8*i +: 8])
				| ({8{plan.strb1[i+4]}} & last_beat[8*(i+4) +: 8]);
		end
	end

	// bring the byte at addr_low down to lane 0
	assign shifted = {group, group} >> {addr_low, 3'b000};
	assign rotated = shifted[`MAU_DATA_W-1:0];

	// ---------------------------------------------------------
	// extend for the operation
	// ---------------------------------------------------------

	always_comb begin
		case (op)
			OP_LH: begin
				load_data = {{16{rotated[15]}}, rotated[15:0]};
			end
			OP_LHU: begin
				load_data = {16'h0000, rotated[15:0]};
			end
			OP_LB: begin
				load_data = {{24{rotated[7]}}, rotated[7:0]};
			end
			OP_LBU: begin
				load_data = {24'h000000, rotated[7:0]};
			end
			// lw, and stores which nobody reads
			default: begin
				load_data = rotated;
			end
		endcase
	end

endmodule

/* rtl/mem_access_unit.sv */
`timescale 1ns/1ps
`include "mau_defines.svh"

module mem_access_unit (
	input  logic                   clock,
	input  logic                   reset,
	input  mau_pkg::mem_req_t      req,
	input  logic                   req_valid,
	output logic                   req_allowin,
	output logic                   mem_done,
	output logic [`MAU_DATA_W-1:0] load_data,
	output mau_pkg::axi_ar_t       ar,
	output logic                   arvalid,
	input  logic                   arready,
	input  mau_pkg::axi_r_t        r,
	input  logic                   rvalid,
	output logic                   rready,
	output mau_pkg::axi_aw_t       aw,
	output logic                   awvalid,
	input  logic                   awready,
	output mau_pkg::axi_w_t        w,
	output logic                   wvalid,
	input  logic                   wready,
	input  mau_pkg::axi_b_t        b,
	input  logic                   bvalid,
	output logic                   bready
);
	import mau_pkg::*;

	mem_req_t              req_q;
	logic                  valid_q;
	logic                  launch;
	logic [`MAU_ID_W-1:0]  txn_id;
	logic                  is_load;
	logic                  read_done;
	logic                  write_done;
	lane_plan_t            plan;
	logic [`MAU_BUS_W-1:0] first_beat;
	logic [`MAU_BUS_W-1:0] last_beat;

	// ---------------------------------------------------------
	// request register and handshake
	// ---------------------------------------------------------

	assign mem_done    = read_done | write_done;
	assign req_allowin = !valid_q || mem_done;
	assign is_load     = req_q.op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};

	// launch pulses once, in the first cycle a request sits in req_q
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
			launch  <= 1'b0;
			txn_id  <= '0;
		end else begin
			if (req_allowin) begin
				valid_q <= req_valid;
			end
			launch <= req_allowin && req_valid;
			txn_id <= txn_id + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (req_allowin && req_valid) begin
			req_q <= req;
		end
	end

	// ---------------------------------------------------------
	// datapath
	// ---------------------------------------------------------

	lane_planner lane_planner_inst (
		.op         (req_q.op),
		.addr       (req_q.addr),
		.store_data (req_q.data),
		.plan       (plan)
	);

	axi_read_fsm axi_read_fsm_inst (
		.clock      (clock),
		.reset      (reset),
		.start      (launch && is_load),
		.plan       (plan),
		.txn_id     (txn_id),
		.ar         (ar),
		.arvalid    (arvalid),
		.arready    (arready),
		.r          (r),
		.rvalid     (rvalid),
		.rready     (rready),
		.first_beat (first_beat),
		.last_beat  (last_beat),
		.read_done  (read_done)
	);

	axi_write_fsm axi_write_fsm_inst (
		.clock      (clock),
		.reset      (reset),
		.start      (launch && !is_load),
		.plan       (plan),
		.txn_id     (txn_id),
		.aw         (aw),
		.awvalid    (awvalid),
		.awready    (awready),
		.w          (w),
		.wvalid     (wvalid),
		.wready     (wready),
		.b          (b),
		.bvalid     (bvalid),
		.bready     (bready),
		.write_done (write_done)
	);

	load_aligner load_aligner_inst (
		.plan       (plan),
		.op         (req_q.op),
		.addr_low   (req_q.addr[1:0]),
		.first_beat (first_beat),
		.last_beat  (last_beat),
		.load_data  (load_data)
	);

	// a done from either FSM must belong to the held request
	done_needs_request: assert property (@(posedge clock) disable iff (reset)
		mem_done |-> valid_q);

endmodule

/* verification/axi_mem_model.sv */
`timescale 1ns/1ps
`include "mau_defines.svh"

module axi_mem_model (
	input  logic             clock,
	input  mau_pkg::axi_ar_t ar,
	input  logic             arvalid,
	output logic             arready,
	output mau_pkg::axi_r_t  r,
	output logic             rvalid,
	input  logic             rready,
	input  mau_pkg::axi_aw_t aw,
	input  logic             awvalid,
	output logic             awready,
	input  mau_pkg::axi_w_t  w,
	input  logic             wvalid,
	output logic             wready,
	output mau_pkg::axi_b_t  b,
	output logic             bvalid,
	input  logic             bready
);
	import mau_pkg::*;

	localparam int MEM_BYTES = 128;

	logic [7:0] mem [0:MEM_BYTES-1];

	// odd multiplier keeps every byte distinct
	initial begin
		for (int i = 0; i < MEM_BYTES; i++) begin
			mem[i] = 8'(i * 29 + 17);
		end
	end

	// each wait ends 1 ns after an edge
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	// whole beat at the address rounded down to 8
	function automatic logic [`MAU_BUS_W-1:0] beat_at(input logic [`MAU_ADDR_W-1:0] addr);
		logic [`MAU_BUS_W-1:0] beat;
		for (int k = 0; k < `MAU_STRB_W; k++) begin
			beat[8*k +: 8] = mem[{addr[6:3], 3'(k)}];
		end
		return beat;
	endfunction

	task automatic answer_read(input logic [`MAU_BUS_W-1:0] data,
			input logic [`MAU_ID_W-1:0] id);
		r.data = data;
		r.id   = id;
		r.resp = 2'b00;
		rvalid = 1'b1;
		do begin
			@(posedge clock);
		end while (!rready);
		#1 rvalid = 1'b0;
	endtask

	task automatic answer_write(input logic [`MAU_ID_W-1:0] id);
		b.id   = id;
		b.resp = 2'b00;
		bvalid = 1'b1;
		do begin
			@(posedge clock);
		end while (!bready);
		#1 bvalid = 1'b0;
	endtask

	// ---------------------------------------------------------
	// read side
	// ---------------------------------------------------------

	initial begin : read_side
		logic [`MAU_ADDR_W-1:0] addr;
		logic [`MAU_ID_W-1:0]   id;
		arready = 1'b0;
		rvalid  = 1'b0;
		r       = '0;
		forever begin
			@(posedge clock);
			if (arvalid) begin
				#1;
				idle_cycles($urandom % 4);
				arready = 1'b1;
				@(posedge clock);
				addr = ar.addr;
				id   = ar.id;
				#1 arready = 1'b0;
				idle_cycles($urandom % 4);
				// now and then a stale id with junk data first
				if ($urandom % 8 == 0) begin
					answer_read(~beat_at(addr), id ^ 4'h5);
				end
				answer_read(beat_at(addr), id);
			end
		end
	end

	// ---------------------------------------------------------
	// write side
	// ---------------------------------------------------------

	initial begin : write_side
		logic [`MAU_ADDR_W-1:0] addr;
		logic [`MAU_ID_W-1:0]   id;
		logic [7:0]             base;
		awready = 1'b0;
		wready  = 1'b0;
		bvalid  = 1'b0;
		b       = '0;
		forever begin
			@(posedge clock);
			if (awvalid) begin
				#1;
				idle_cycles($urandom % 4);
				awready = 1'b1;
				@(posedge clock);
				addr = aw.addr;
				id   = aw.id;
				#1 awready = 1'b0;
				do begin
					@(posedge clock);
				end while (!wvalid);
				#1;
				idle_cycles($urandom % 4);
				wready = 1'b1;
				@(posedge clock);
				// only strobed lanes land in memory
				base = {1'b0, addr[6:3], 3'b000};
				for (int k = 0; k < `MAU_STRB_W; k++) begin
					if (w.strb[k]) begin
						mem[base + k] = w.data[8*k +: 8];
					end
				end
				#1 wready = 1'b0;
				idle_cycles($urandom % 4);
				if ($urandom % 8 == 0) begin
					answer_write(id ^ 4'h5);
				end
				answer_write(id);
			end
		end
	end

endmodule

/* verification/tb_mem_access_unit.sv */
`timescale 1ns/1ps
`include "mau_defines.svh"

module tb_mem_access_unit;
	import mau_pkg::*;

	localparam int          NUM_REQS       = 200;
	localparam int          CYCLES_PER_REQ = 40;
	localparam int          CYCLE_LIMIT    = NUM_REQS * CYCLES_PER_REQ;
	localparam int          MEM_BYTES      = 128;
	localparam logic [31:0] SEED           = 32'h9a3d;

	logic                   clock;
	logic                   reset;
	mem_req_t               req;
	logic                   req_valid;
	logic                   req_allowin;
	logic                   mem_done;
	logic [`MAU_DATA_W-1:0] load_data;
	axi_ar_t                ar;
	logic                   arvalid;
	logic                   arready;
	axi_r_t                 r;
	logic                   rvalid;
	logic                   rready;
	axi_aw_t                aw;
	logic                   awvalid;
	logic                   awready;
	axi_w_t                 w;
	logic                   wvalid;
	logic                   wready;
	axi_b_t                 b;
	logic                   bvalid;
	logic                   bready;

	// reference memory and the request in flight
	logic [7:0]             ref_mem [0:MEM_BYTES-1];
	logic                   seen_request;
	logic                   busy;
	logic [1:0]             xfers;
	logic [`MAU_ID_W-1:0]   last_id;
	logic                   cur_load;
	logic                   cur_split;
	logic [`MAU_ADDR_W-1:0] cur_addr0;
	logic [`MAU_ADDR_W-1:0] cur_addr1;
	logic [`MAU_STRB_W-1:0] cur_strb0;
	logic [`MAU_STRB_W-1:0] cur_strb1;
	logic [2:0]             cur_size;
	logic [`MAU_DATA_W-1:0] cur_expect;

	int data_errors;
	int beat_errors;
	int protocol_errors;
	int other_errors;
	int loads_done;
	int stores_done;
	int split_loads;
	int split_stores;
	int stale_count;

	mem_access_unit mem_access_unit_inst (
		.clock       (clock),
		.reset       (reset),
		.req         (req),
		.req_valid   (req_valid),
		.req_allowin (req_allowin),
		.mem_done    (mem_done),
		.load_data   (load_data),
		.ar          (ar),
		.arvalid     (arvalid),
		.arready     (arready),
		.r           (r),
		.rvalid      (rvalid),
		.rready      (rready),
		.aw          (aw),
		.awvalid     (awvalid),
		.awready     (awready),
		.w           (w),
		.wvalid      (wvalid),
		.wready      (wready),
		.b           (b),
		.bvalid      (bvalid),
		.bready      (bready)
	);

	axi_mem_model mem_model_inst (
		.clock   (clock),
		.ar      (ar),
		.arvalid (arvalid),
		.arready (arready),
		.r       (r),
		.rvalid  (rvalid),
		.rready  (rready),
		.aw      (aw),
		.awvalid (awvalid),
		.awready (awready),
		.w       (w),
		.wvalid  (wvalid),
		.wready  (wready),
		.b       (b),
		.bvalid  (bvalid),
		.bready  (bready)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// ---------------------------------------------------------
	// access rules
	// ---------------------------------------------------------

	function automatic int access_bytes(input mem_op_e op);
		case (op)
			OP_LW, OP_SW: return 4;
			OP_LH, OP_LHU, OP_SH: return 2;
			default: return 1;
		endcase
	endfunction

	function automatic logic is_load_op(input mem_op_e op);
		return op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};
	endfunction

	function automatic logic crosses_word(input mem_op_e op, input logic [31:0] addr);
		if (access_bytes(op) == 4) begin
			return addr[1:0] != 2'b00;
		end
		return (access_bytes(op) == 2) && (addr[1:0] == 2'b11);
	endfunction

	function automatic logic [2:0] size_code(input mem_op_e op);
		case (access_bytes(op))
			4: return 3'd2;
			2: return 3'd1;
			default: return 3'd0;
		endcase
	endfunction

	// first beat in the low byte, second beat in the high byte
	function automatic logic [15:0] beat_strobes(input mem_op_e op, input logic [31:0] addr);
		logic [15:0] strobes;
		logic [31:0] a;
		strobes = '0;
		for (int k = 0; k < access_bytes(op); k++) begin
			a = addr + k;
			if (a[31:2] == addr[31:2]) begin
				strobes[a[2:0]] = 1'b1;
			end else begin
				strobes[8 + a[2:0]] = 1'b1;
			end
		end
		return strobes;
	endfunction

	// bytes from the address upwards, little-endian
	function automatic logic [31:0] predict_load(input mem_op_e op, input logic [31:0] addr);
		logic [31:0] raw;
		int          base;
		base = addr[6:0];
		raw  = {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
		case (op)
			OP_LH: return {{16{raw[15]}}, raw[15:0]};
			OP_LHU: return {16'h0000, raw[15:0]};
			OP_LB: return {{24{raw[7]}}, raw[7:0]};
			OP_LBU: return {24'h000000, raw[7:0]};
			default: return raw;
		endcase
	endfunction

	function automatic void apply_store(input mem_op_e op, input logic [31:0] addr,
			input logic [31:0] data);
		int base;
		base = addr[6:0];
		for (int k = 0; k < access_bytes(op); k++) begin
			ref_mem[base + k] = data[8*k +: 8];
		end
	endfunction

	function automatic logic [31:0] place_address(input mem_op_e op, input logic [31:0] addr,
			input logic misaligned);
		case (access_bytes(op))
			4: return misaligned ? {addr[31:2], 2'(1 + $urandom % 3)} : {addr[31:2], 2'b00};
			2: return misaligned ? (addr | 32'd1) : {addr[31:1], 1'b0};
			default: return addr;
		endcase
	endfunction

	// ---------------------------------------------------------
	// stimulus helpers
	// ---------------------------------------------------------

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic issue_request(input mem_op_e op, input logic [31:0] addr,
			input logic [31:0] data);
		req.op    = op;
		req.addr  = addr;
		req.data  = data;
		req_valid = 1'b1;
		do begin
			@(posedge clock);
		end while (!req_allowin);
		#1 req_valid = 1'b0;
	endtask

	task automatic print_summary();
		$write("errors: data %0d, beat %0d, protocol %0d, other %0d; ",
			data_errors, beat_errors, protocol_errors, other_errors);
		$display("loads %0d, stores %0d, stale responses %0d",
			loads_done, stores_done, stale_count);
	endtask

	// ---------------------------------------------------------
	// reference model and request tracking
	// ---------------------------------------------------------

	always @(posedge clock) begin
		if (reset) begin
			seen_request <= 1'b0;
			busy         <= 1'b0;
			xfers        <= '0;
			last_id      <= '0;
		end else begin
			if (req_valid && req_allowin) begin
				seen_request <= 1'b1;
				busy         <= 1'b1;
				xfers        <= '0;
				cur_load     <= is_load_op(req.op);
				cur_split    <= crosses_word(req.op, req.addr);
				cur_addr0    <= req.addr;
				cur_addr1    <= {req.addr[31:2], 2'b00} + 32'd4;
				cur_size     <= size_code(req.op);
				{cur_strb1, cur_strb0} <= beat_strobes(req.op, req.addr);
				cur_expect   <= predict_load(req.op, req.addr);
				if (!is_load_op(req.op)) begin
					apply_store(req.op, req.addr, req.data);
				end
			end else begin
				if (mem_done) begin
					busy <= 1'b0;
				end
				if ((arvalid && arready) || (awvalid && awready)) begin
					xfers <= xfers + 2'd1;
				end
			end
			if (arvalid && arready) begin
				last_id <= ar.id;
			end
			if (awvalid && awready) begin
				last_id <= aw.id;
			end
			if ((rvalid && rready && r.id != last_id) ||
				(bvalid && bready && b.id != last_id)) begin
				stale_count <= stale_count + 1;
			end
			if (mem_done && cur_load) begin
				loads_done  <= loads_done + 1;
				split_loads <= split_loads + int'(cur_split);
			end
			if (mem_done && !cur_load) begin
				stores_done  <= stores_done + 1;
				split_stores <= split_stores + int'(cur_split);
			end
		end
	end

	// ---------------------------------------------------------
	// checks
	// ---------------------------------------------------------

	quiet_before_request: assert property (@(posedge clock) disable iff (reset)
		!seen_request |-> !(arvalid || awvalid || wvalid || rready || bready || mem_done))
	else begin
		protocol_errors++;
		$display("ERROR a bus valid, a bus ready or mem_done was high before any request");
	end

	load_matches: assert property (@(posedge clock) disable iff (reset)
		mem_done && cur_load |-> load_data == cur_expect)
	else begin
		data_errors++;
		$display("ERROR load_data %h expected %h", $sampled(load_data), $sampled(cur_expect));
	end

	transfer_count: assert property (@(posedge clock) disable iff (reset)
		mem_done |-> xfers == (cur_split ? 2'd2 : 2'd1))
	else begin
		beat_errors++;
		$display("ERROR address transfers %h expected %h", $sampled(xfers),
			$sampled(cur_split ? 2'd2 : 2'd1));
	end

	ar_beat: assert property (@(posedge clock) disable iff (reset)
		arvalid && arready |-> ar.addr == (xfers == 2'd0 ? cur_addr0 : cur_addr1)
			&& ar.size == cur_size)
	else begin
		beat_errors++;
		$display("ERROR ar.addr %h size %h expected %h size %h", $sampled(ar.addr),
			$sampled(ar.size), $sampled(xfers == 2'd0 ? cur_addr0 : cur_addr1),
			$sampled(cur_size));
	end

	aw_beat: assert property (@(posedge clock) disable iff (reset)
		awvalid && awready |-> aw.addr == (xfers == 2'd0 ? cur_addr0 : cur_addr1)
			&& aw.size == cur_size)
	else begin
		beat_errors++;
		$display("ERROR aw.addr %h size %h expected %h size %h", $sampled(aw.addr),
			$sampled(aw.size), $sampled(xfers == 2'd0 ? cur_addr0 : cur_addr1),
			$sampled(cur_size));
	end

	// the aw transfer of this beat is already counted
	w_strobe: assert property (@(posedge clock) disable iff (reset)
		wvalid && wready |-> w.strb == (xfers == 2'd1 ? cur_strb0 : cur_strb1) && w.last)
	else begin
		beat_errors++;
		$display("ERROR w.strb %h last %h expected %h last 1", $sampled(w.strb),
			$sampled(w.last), $sampled(xfers == 2'd1 ? cur_strb0 : cur_strb1));
	end

	ar_stable: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(ar))
	else begin
		protocol_errors++;
		$display("ERROR arvalid or ar changed while arready was low");
	end

	aw_stable: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(aw))
	else begin
		protocol_errors++;
		$display("ERROR awvalid or aw changed while awready was low");
	end

	w_stable: assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(w))
	else begin
		protocol_errors++;
		$display("ERROR wvalid or w changed while wready was low");
	end

	allowin_low_while_busy: assert property (@(posedge clock) disable iff (reset)
		busy && !mem_done |-> !req_allowin)
	else begin
		protocol_errors++;
		$display("ERROR req_allowin %h expected 0", $sampled(req_allowin));
	end

	stale_read_ignored: assert property (@(posedge clock) disable iff (reset)
		rvalid && rready && r.id != last_id |=> !mem_done)
	else begin
		protocol_errors++;
		$display("ERROR mem_done followed a read response with a stale id");
	end

	stale_write_ignored: assert property (@(posedge clock) disable iff (reset)
		bvalid && bready && b.id != last_id |=> !mem_done)
	else begin
		protocol_errors++;
		$display("ERROR mem_done followed a write response with a stale id");
	end

	// ---------------------------------------------------------
	// stimulus
	// ---------------------------------------------------------

	initial begin : stimulus
		mem_op_e                op;
		logic [`MAU_ADDR_W-1:0] addr;
		void'($urandom(SEED));
		reset     = 1'b1;
		req       = '0;
		req_valid = 1'b0;
		data_errors     = 0;
		beat_errors     = 0;
		protocol_errors = 0;
		other_errors    = 0;
		loads_done      = 0;
		stores_done     = 0;
		split_loads     = 0;
		split_stores    = 0;
		stale_count     = 0;
		for (int i = 0; i < MEM_BYTES; i++) begin
			ref_mem[i] = 8'(i * 29 + 17);
		end
		repeat (2) @(posedge clock);
		#1 reset = 1'b0;
		idle_cycles(5);

		// even requests aligned and odd ones misaligned where the size allows
		for (int i = 0; i < NUM_REQS; i++) begin
			op   = mem_op_e'($urandom % 8);
			addr = place_address(op, $urandom % 64, i % 2 == 1);
			issue_request(op, addr, $urandom);
			idle_cycles($urandom % 3);
		end
		while (busy) begin
			@(posedge clock);
		end

		if (stale_count == 0) begin
			other_errors++;
			$display("no response with a stale id reached the DUT");
		end
		if (split_loads == 0 || split_stores == 0) begin
			other_errors++;
			$display("split loads or split stores were never completed");
		end
		print_summary();
		if (data_errors + beat_errors + protocol_errors + other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		$display("run stopped after %0d cycles, requests did not finish in time", cycles);
		print_summary();
		$display("Checks failed");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+rtl
rtl/mau_pkg.sv
rtl/lane_planner.sv
rtl/axi_read_fsm.sv
rtl/axi_write_fsm.sv
rtl/load_aligner.sv
rtl/mem_access_unit.sv
verification/axi_mem_model.sv
verification/tb_mem_access_unit.sv

/* Bender.yml */
package:
  name: mem_access_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mau_pkg.sv
      - rtl/lane_planner.sv
      - rtl/axi_read_fsm.sv
      - rtl/axi_write_fsm.sv
      - rtl/load_aligner.sv
      - rtl/mem_access_unit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/axi_mem_model.sv
      - verification/tb_mem_access_unit.sv
